/* verilog.f */
design/rv_pkg.sv
design/rv_decode_if.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_lsu.sv
design/rv_core.sv
bench/rv_core_asserts.sv
bench/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - design/rv_pkg.sv
  - design/rv_decode_if.sv
  - design/rv_fetch.sv
  - design/rv_decode.sv
  - design/rv_regfile.sv
  - design/rv_alu.sv
  - design/rv_lsu.sv
  - design/rv_core.sv
  - target: simulation
    files:
      - bench/rv_core_asserts.sv
      - bench/tb_rv_core.sv

/* bench/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam int PROG_WORDS      = 139;  // Sum of all test program lengths
    localparam int WATCHDOG_CYCLES = PROG_WORDS * 8;
    localparam logic [31:0] LOOP_INSN = 32'h0000_006f;  // jal x0, 0

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [63:0] pc, bus_addr, bus_wdata, bus_rdata, pc_off;
    logic        bus_we, bus_re;
    logic [31:0] imem [128];
    logic [63:0] dmem [32];
    logic [63:0] st_addr_q[$], st_data_q[$], exp_addr_q[$], exp_data_q[$];
    logic [31:0] lfsr;
    logic        re_seen;
    int          errors;
    int          prog_len;

    rv_core uut (
        .clk           (clk),
        .reset         (reset),
        .instruction_i (instruction),
        .pc_o          (pc),
        .bus_addr_o    (bus_addr),
        .bus_wdata_o   (bus_wdata),
        .bus_we_o      (bus_we),
        .bus_re_o      (bus_re),
        .bus_rdata_i   (bus_rdata)
    );

    always #50 clk = ~clk;

    // Memory models answer combinationally
    assign pc_off      = pc - rv_pkg::RAM_BASE;
    assign instruction = imem[pc_off[8:2]];
    assign bus_rdata   = dmem[bus_addr[7:3]];

    always @(negedge clk) begin
        if (reset && bus_we) begin
            st_addr_q.push_back(bus_addr);
            st_data_q.push_back(bus_wdata);
        end
        if (reset && bus_re && bus_addr == 64'h40) re_seen = 1'b1;
    end

    // Galois LFSR, one step per bit
    function automatic logic [63:0] next_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic alt,
                                          input logic [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [11:0] off);
        return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                          input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    // Reference arithmetic from the RV64I rules
    function automatic logic [63:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [63:0] a, b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return {63'b0, $signed(a) < $signed(b)};
            3'd3: return {63'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic ref_taken(input logic [2:0] f3, input logic [63:0] a, b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check(input string name, input logic [63:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic emit(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // LUI plus ADDI, returns the value the register will hold
    task automatic put_const(input logic [4:0] rd, input logic [31:0] v,
                             output logic [63:0] val);
        logic [31:0] t;
        t = v + 32'h800;
        emit({t[31:12], rd, rv_pkg::OP_LUI});
        emit(enc_i(rv_pkg::OP_IMM, 3'd0, rd, rd, v[11:0]));
        val = {{32{t[31]}}, t[31:12], 12'b0} + {{52{v[11]}}, v[11:0]};
    endtask

    task automatic expect_store(input logic [11:0] addr, input logic [63:0] value);
        exp_addr_q.push_back({52'b0, addr});
        exp_data_q.push_back({32'b0, value[31:0]});
    endtask

    task automatic enter_reset();
        @(posedge clk);
        reset <= 1'b0;
        foreach (imem[i]) imem[i] = LOOP_INSN;
        prog_len = 0;
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic leave_reset();
        repeat (9) @(posedge clk);
        st_addr_q.delete();
        st_data_q.delete();
        re_seen = 1'b0;
        reset <= 1'b1;
    endtask

    task automatic compare_stores(input string test);
        int waited;
        waited = 0;
        while (st_addr_q.size() < exp_addr_q.size() && waited < prog_len * 8) begin
            @(negedge clk);
            waited++;
        end
        if (st_addr_q.size() < exp_addr_q.size()) begin
            errors++;
            $display("%s: timed out waiting for stores, saw %0d of %0d", test,
                     st_addr_q.size(), exp_addr_q.size());
        end
        repeat (4) @(negedge clk);  // Catch stray stores
        check({test, " store count"}, st_addr_q.size(), exp_addr_q.size());
        for (int i = 0; i < exp_addr_q.size() && i < st_addr_q.size(); i++) begin
            check({test, " bus_addr_o"}, st_addr_q[i], exp_addr_q[i]);
            check({test, " bus_wdata_o"}, st_data_q[i], exp_data_q[i]);
        end
    endtask

    task automatic test_reset();
        enter_reset();
        emit(rv_pkg::NOP_INSN);
        @(negedge clk);
        check("pc_o", pc, rv_pkg::RAM_BASE);
        check("bus_we_o", bus_we, 1'b0);
        check("bus_re_o", bus_re, 1'b0);
        check("bus_addr_o", bus_addr, rv_pkg::RAM_BASE);
        leave_reset();
        @(negedge clk);
        check("instruction_i", instruction, rv_pkg::NOP_INSN);  // First fetch at RAM_BASE
        @(negedge clk);
        check("pc_o", pc, rv_pkg::RAM_BASE + 64'd4);
    endtask

    task automatic test_imm_ops();
        logic [2:0]  f3_list [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
        logic [63:0] a, b;
        logic [11:0] imm;
        logic        alt;
        enter_reset();
        put_const(5'd1, 32'(next_bits(32)), a);
        for (int k = 0; k < 9; k++) begin
            alt = (k == 8);  // SRAI
            if (f3_list[k] == 3'd1 || f3_list[k] == 3'd5) begin
                imm = {1'b0, alt, 4'b0, 6'(next_bits(6))};
                b   = {58'b0, imm[5:0]};
            end else begin
                imm = 12'(next_bits(12));
                b   = {{52{imm[11]}}, imm};
            end
            emit(enc_i(rv_pkg::OP_IMM, f3_list[k], 5'd2, 5'd1, imm));
            emit(enc_sw(5'd2, 12'h100 + k * 8));
            expect_store(12'h100 + k * 8, ref_alu(f3_list[k], alt, a, b));
        end
        leave_reset();
        compare_stores("imm_ops");
    endtask

    task automatic test_reg_ops();
        logic [2:0]  f3_list [10] = '{0, 0, 1, 5, 5, 2, 3, 4, 6, 7};
        logic        alt_list [10] = '{0, 1, 0, 0, 1, 0, 0, 0, 0, 0};
        logic [63:0] a, b;
        enter_reset();
        put_const(5'd1, 32'(next_bits(32)), a);
        put_const(5'd2, 32'(next_bits(32)), b);
        emit(enc_r(3'd0, 1'b0, 5'd0, 5'd1, 5'd2));  // Write to x0 is dropped
        emit(enc_sw(5'd0, 12'h1f8));  // x0 reads zero
        expect_store(12'h1f8, 64'd0);
        for (int k = 0; k < 10; k++) begin
            emit(enc_r(f3_list[k], alt_list[k], 5'd3, 5'd1, 5'd2));
            emit(enc_sw(5'd3, 12'h180 + k * 8));
            expect_store(12'h180 + k * 8, ref_alu(f3_list[k], alt_list[k], a, b));
        end
        leave_reset();
        compare_stores("reg_ops");
    endtask

    task automatic test_branches();
        logic [2:0]  f3_list [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [4:0]  r1_list [3] = '{5'd1, 5'd1, 5'd2};
        logic [4:0]  r2_list [3] = '{5'd1, 5'd2, 5'd1};
        logic [63:0] val [3];
        logic [31:0] va, vb;
        logic [11:0] addr;
        enter_reset();
        va = 32'(next_bits(32));
        vb = 32'(next_bits(32));
        if (vb == va) vb = ~va;
        put_const(5'd1, va, val[1]);
        put_const(5'd2, vb, val[2]);
        emit(enc_i(rv_pkg::OP_IMM, 3'd0, 5'd5, 5'd0, 12'h00a));  // Not taken marker
        emit(enc_i(rv_pkg::OP_IMM, 3'd0, 5'd6, 5'd0, 12'h07b));  // Taken marker
        for (int t = 0; t < 6; t++) begin
            for (int p = 0; p < 3; p++) begin
                addr = 12'h200 + (t * 3 + p) * 8;
                emit(enc_b(f3_list[t], r1_list[p], r2_list[p], 13'd12));
                emit(enc_sw(5'd5, addr));
                emit(enc_j(5'd0, 21'd8));
                emit(enc_sw(5'd6, addr));
                expect_store(addr, ref_taken(f3_list[t], val[r1_list[p]], val[r2_list[p]]) ?
                             64'h7b : 64'h0a);
            end
        end
        leave_reset();
        compare_stores("branches");
    endtask

    task automatic test_jumps();
        enter_reset();
        emit(enc_j(5'd7, 21'd12));
        emit(enc_sw(5'd8, 12'h3f0));  // Flushed
        emit(enc_sw(5'd8, 12'h3f0));  // Skipped
        emit(enc_sw(5'd7, 12'h380));
        emit({20'd0, 5'd9, rv_pkg::OP_AUIPC});
        emit(enc_i(rv_pkg::OP_JALR, 3'd0, 5'd10, 5'd9, 12'd13));  // Odd target
        emit(enc_sw(5'd8, 12'h3f0));
        emit(enc_sw(5'd10, 12'h388));
        emit({20'd0, 5'd9, rv_pkg::OP_AUIPC});  // Shows where execution resumed
        emit(enc_sw(5'd9, 12'h390));
        expect_store(12'h380, rv_pkg::RAM_BASE + 64'd4);
        expect_store(12'h388, rv_pkg::RAM_BASE + 64'd24);
        expect_store(12'h390, rv_pkg::RAM_BASE + 64'd32);
        leave_reset();
        compare_stores("jumps");
    endtask

    task automatic test_load_store();
        logic [31:0] word;
        enter_reset();
        foreach (dmem[i]) dmem[i] = {32'hd00d_0000 | i, 32'h1000_0000 + i * 32'h0101};
        word    = {1'b1, 31'(next_bits(31))};  // Negative word
        dmem[8] = {32'(next_bits(32)), word};
        emit(enc_i(rv_pkg::OP_LOAD, 3'b010, 5'd11, 5'd0, 12'h040));
        emit(enc_sw(5'd11, 12'h3a0));
        emit(enc_i(rv_pkg::OP_IMM, 3'd5, 5'd12, 5'd11, {6'b010000, 6'd32}));
        emit(enc_sw(5'd12, 12'h3a8));
        expect_store(12'h3a0, {32'b0, word});
        expect_store(12'h3a8, 64'hffff_ffff);  // Upper half of the sign extension
        leave_reset();
        compare_stores("load_store");
        check("bus_re_o seen", re_seen, 1'b1);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        clk     = 1'b0;
        reset   = 1'b0;
        lfsr    = 32'h99b0;
        errors  = 0;
        re_seen = 1'b0;
        foreach (imem[i]) imem[i] = LOOP_INSN;
        foreach (dmem[i]) dmem[i] = {32'hd00d_0000 | i, 32'h1000_0000 + i * 32'h0101};
        test_reset();
        test_imm_ops();
        test_reg_ops();
        test_branches();
        test_jumps();
        test_load_store();
        $display("Tests done with %0d errors and %0d assertion failures", errors,
                 uut.u_asserts.failures);
        if (errors == 0 && uut.u_asserts.failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* bench/rv_core_asserts.sv */
`timescale 1ns/1ps

module rv_core_asserts (
    input logic                    clk,
    input logic                    reset,
    input logic [rv_pkg::XLEN-1:0] pc_i,
    input logic                    bus_we_i,
    input logic                    bus_re_i,
    input logic                    redirect_i,
    input logic                    replay_i
);

    int failures = 0;  // Failed assertion count

    // Read and write strobes are exclusive
    assert property (@(posedge clk) disable iff (!reset) !(bus_we_i && bus_re_i))
        else begin
            $error("bus_we_o and bus_re_o high together");
            failures++;
        end

    assert property (@(posedge clk) disable iff (!reset) bus_we_i |=> !bus_we_i)
        else begin
            $error("bus_we_o held longer than one cycle");
            failures++;
        end

    // Sequential fetch unless the last cycle redirected or replayed
    assert property (@(posedge clk) disable iff (!reset)
        !(redirect_i || replay_i) |=> pc_i == $past(pc_i) + rv_pkg::PC_STEP)
        else begin
            $error("pc_o did not advance by four");
            failures++;
        end

endmodule

bind rv_core rv_core_asserts u_asserts (
    .clk        (clk),
    .reset      (reset),
    .pc_i       (pc_o),
    .bus_we_i   (bus_we_o),
    .bus_re_i   (bus_re_o),
    .redirect_i (redirect),
    .replay_i   (replay)
);

/* design/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [rv_pkg::ILEN-1:0] instruction_i,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output logic [rv_pkg::XLEN-1:0] bus_addr_o,
    output logic [rv_pkg::XLEN-1:0] bus_wdata_o,
    output logic                    bus_we_o,
    output logic                    bus_re_o,
    input  logic [rv_pkg::XLEN-1:0] bus_rdata_i
);

    logic [rv_pkg::ILEN-1:0] ir;
    logic                    ir_valid;
    logic                    redirect;
    logic [rv_pkg::XLEN-1:0] target;
    logic                    replay;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;
    logic                    wb_we;
    logic [rv_pkg::XLEN-1:0] wb_data;
    logic                    load_we;
    logic [rv_pkg::XLEN-1:0] load_data;

    rv_decode_if dec_if ();

    rv_fetch u_fetch (
        .clk           (clk),
        .reset         (reset),
        .instruction_i (instruction_i),
        .redirect_i    (redirect),
        .target_i      (target),
        .replay_i      (replay),
        .pc_o          (pc_o),
        .ir_o          (ir),
        .valid_o       (ir_valid)
    );

    rv_decode u_decode (
        .ir_i    (ir),
        .valid_i (ir_valid),
        .dec     (dec_if)
    );

    rv_regfile u_regfile (
        .clk         (clk),
        .reset       (reset),
        .dec         (dec_if),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .alu_we_i    (wb_we),
        .alu_data_i  (wb_data),
        .load_we_i   (load_we),
        .load_data_i (load_data)
    );

    // pc_o is one word ahead of the executing instruction
    rv_alu u_alu (
        .dec        (dec_if),
        .pc_i       (pc_o),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .wb_we_o    (wb_we),
        .wb_data_o  (wb_data),
        .redirect_o (redirect),
        .target_o   (target)
    );

    rv_lsu u_lsu (
        .clk         (clk),
        .reset       (reset),
        .dec         (dec_if),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .bus_rdata_i (bus_rdata_i),
        .replay_o    (replay),
        .load_we_o   (load_we),
        .load_data_o (load_data),
        .bus_addr_o  (bus_addr_o),
        .bus_wdata_o (bus_wdata_o),
        .bus_we_o    (bus_we_o),
        .bus_re_o    (bus_re_o)
    );

endmodule

/* design/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu (
    input  logic                    clk,
    input  logic                    reset,
    rv_decode_if.consumer           dec,
    input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
    input  logic [rv_pkg::XLEN-1:0] bus_rdata_i,
    output logic                    replay_o,
    output logic                    load_we_o,
    output logic [rv_pkg::XLEN-1:0] load_data_o,
    output logic [rv_pkg::XLEN-1:0] bus_addr_o,
    output logic [rv_pkg::XLEN-1:0] bus_wdata_o,
    output logic                    bus_we_o,
    output logic                    bus_re_o
);

    logic                    step;  // Set between issue and capture of a load
    logic                    is_load;
    logic                    is_store;
    logic [rv_pkg::XLEN-1:0] addr;

    assign addr     = rs1_data_i + dec.imm;
    assign is_load  = dec.valid && (dec.cls == rv_pkg::CL_LOAD);
    assign is_store = dec.valid && (dec.cls == rv_pkg::CL_STORE);

    // First pass issues and replays, second pass writes back
    assign replay_o    = is_load && !step;
    assign load_we_o   = is_load && step;
    assign load_data_o = {{(rv_pkg::XLEN-32){bus_rdata_i[31]}}, bus_rdata_i[31:0]};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            step       <= 1'b0;
            bus_re_o   <= 1'b0;
            bus_we_o   <= 1'b0;
            bus_addr_o <= rv_pkg::RAM_BASE;
        end else begin
            bus_we_o <= is_store;  // One cycle strobe
            if (replay_o) begin
                step       <= 1'b1;
                bus_re_o   <= 1'b1;
                bus_addr_o <= addr;
            end else if (load_we_o) begin
                step       <= 1'b0;
                bus_re_o   <= 1'b0;
                bus_addr_o <= rv_pkg::RAM_BASE;
            end else if (!step) begin
                bus_addr_o <= is_store ? addr : rv_pkg::RAM_BASE;
            end
            // Read stays up through the bubble until the refetched LW
        end
    end

    always_ff @(posedge clk) begin
        if (is_store) begin
            bus_wdata_o <= {{(rv_pkg::XLEN-32){1'b0}}, rs2_data_i[31:0]};
        end
    end

endmodule

/* design/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
    rv_decode_if.consumer           dec,
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
    output logic                    wb_we_o,
    output logic [rv_pkg::XLEN-1:0] wb_data_o,
    output logic                    redirect_o,
    output logic [rv_pkg::XLEN-1:0] target_o
);

    logic [rv_pkg::XLEN-1:0] insn_pc;   // Address of the executing instruction
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] pc_rel;
    logic [rv_pkg::XLEN-1:0] jalr_sum;
    logic [rv_pkg::XLEN-1:0] result;
    logic [5:0]              shamt;
    logic                    eq;
    logic                    lt_s;
    logic                    lt_u;
    logic                    taken;

    assign insn_pc  = pc_i - rv_pkg::PC_STEP;
    assign op_b     = dec.use_imm ? dec.imm : rs2_data_i;
    assign pc_rel   = insn_pc + dec.imm;  // Branch, JAL and AUIPC
    assign jalr_sum = rs1_data_i + dec.imm;
    assign shamt    = op_b[5:0];

    assign eq   = (rs1_data_i == op_b);
    assign lt_s = ($signed(rs1_data_i) < $signed(op_b));
    assign lt_u = (rs1_data_i < op_b);

    always_comb begin
        case (dec.alu_op)
            rv_pkg::ALU_ADD:  result = rs1_data_i + op_b;
            rv_pkg::ALU_SUB:  result = rs1_data_i - op_b;
            rv_pkg::ALU_XOR:  result = rs1_data_i ^ op_b;
            rv_pkg::ALU_OR:   result = rs1_data_i | op_b;
            rv_pkg::ALU_AND:  result = rs1_data_i & op_b;
            rv_pkg::ALU_SLL:  result = rs1_data_i << shamt;
            rv_pkg::ALU_SRL:  result = rs1_data_i >> shamt;
            rv_pkg::ALU_SRA:  result = $signed(rs1_data_i) >>> shamt;
            rv_pkg::ALU_SLT:  result = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
            rv_pkg::ALU_SLTU: result = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
            rv_pkg::ALU_PASS: result = pc_rel;
            default:          result = '0;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            rv_pkg::F3_BEQ:  taken = eq;
            rv_pkg::F3_BNE:  taken = !eq;
            rv_pkg::F3_BLT:  taken = lt_s;
            rv_pkg::F3_BGE:  taken = !lt_s;
            rv_pkg::F3_BLTU: taken = lt_u;
            rv_pkg::F3_BGEU: taken = !lt_u;
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        wb_we_o    = 1'b0;
        wb_data_o  = result;
        redirect_o = 1'b0;
        target_o   = pc_rel;
        if (dec.valid) begin
            case (dec.cls)
                rv_pkg::CL_ALU: wb_we_o = 1'b1;
                rv_pkg::CL_JAL: begin
                    wb_we_o    = 1'b1;
                    wb_data_o  = pc_i;  // Link is insn_pc plus 4
                    redirect_o = 1'b1;
                end
                rv_pkg::CL_JALR: begin
                    wb_we_o    = 1'b1;
                    wb_data_o  = pc_i;
                    redirect_o = 1'b1;
                    target_o   = {jalr_sum[rv_pkg::XLEN-1:1], 1'b0};
                end
                rv_pkg::CL_BRANCH: redirect_o = taken;
                default: ;
            endcase
        end
    end

endmodule

/* design/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk,
    input  logic                    reset,
    rv_decode_if.consumer           dec,
    output logic [rv_pkg::XLEN-1:0] rs1_data_o,
    output logic [rv_pkg::XLEN-1:0] rs2_data_o,
    input  logic                    alu_we_i,
    input  logic [rv_pkg::XLEN-1:0] alu_data_i,
    input  logic                    load_we_i,
    input  logic [rv_pkg::XLEN-1:0] load_data_i
);

    logic [rv_pkg::XLEN-1:0] regs [2**rv_pkg::REG_ADDR_W];

    assign rs1_data_o = regs[dec.rs1];
    assign rs2_data_o = regs[dec.rs2];

    // x0 is hardwired to zero
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 2**rv_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (dec.rd != '0) begin
            if (load_we_i) begin
                regs[dec.rd] <= load_data_i;  // Load data wins
            end else if (alu_we_i) begin
                regs[dec.rd] <= alu_data_i;
            end
        end
    end

endmodule

/* design/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode (
    input  logic [rv_pkg::ILEN-1:0] ir_i,
    input  logic                    valid_i,
    rv_decode_if.producer           dec
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic                    alt;  // funct7 bit 5, picks SUB and SRA
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [rv_pkg::XLEN-1:0] imm_j;
    logic [rv_pkg::XLEN-1:0] imm_b;
    rv_pkg::alu_op_t         arith_op;

    assign opcode = ir_i[6:0];
    assign funct3 = ir_i[14:12];
    assign alt    = ir_i[30];

    assign imm_u = {{32{ir_i[31]}}, ir_i[31:12], 12'b0};
    assign imm_i = {{52{ir_i[31]}}, ir_i[31:20]};
    assign imm_s = {{52{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign imm_j = {{44{ir_i[31]}}, ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
    assign imm_b = {{52{ir_i[31]}}, ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};

    // Shared by OP_IMM and OP_REG
    always_comb begin
        case (funct3)
            rv_pkg::F3_ADD:  arith_op = (alt && opcode == rv_pkg::OP_REG) ?
                                        rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            rv_pkg::F3_SLL:  arith_op = rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT:  arith_op = rv_pkg::ALU_SLT;
            rv_pkg::F3_SLTU: arith_op = rv_pkg::ALU_SLTU;
            rv_pkg::F3_XOR:  arith_op = rv_pkg::ALU_XOR;
            rv_pkg::F3_SR:   arith_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:   arith_op = rv_pkg::ALU_OR;
            default:         arith_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        dec.valid   = valid_i;
        dec.cls     = rv_pkg::CL_NONE;  // Unknown encodings do nothing
        dec.alu_op  = arith_op;
        dec.use_imm = 1'b1;
        dec.funct3  = funct3;
        dec.rd      = ir_i[11:7];
        dec.rs1     = ir_i[19:15];
        dec.rs2     = ir_i[24:20];
        dec.imm     = imm_i;
        case (opcode)
            rv_pkg::OP_LUI: begin
                dec.cls    = rv_pkg::CL_ALU;
                dec.alu_op = rv_pkg::ALU_ADD;  // x0 plus upper immediate
                dec.rs1    = '0;
                dec.imm    = imm_u;
            end
            rv_pkg::OP_AUIPC: begin
                dec.cls    = rv_pkg::CL_ALU;
                dec.alu_op = rv_pkg::ALU_PASS;
                dec.imm    = imm_u;
            end
            rv_pkg::OP_JAL: begin
                dec.cls = rv_pkg::CL_JAL;
                dec.imm = imm_j;
            end
            rv_pkg::OP_JALR: begin
                if (funct3 == rv_pkg::F3_ADD) dec.cls = rv_pkg::CL_JALR;
            end
            rv_pkg::OP_BRANCH: begin
                // funct3 010 and 011 are not branches
                if (funct3[2:1] != 2'b01) dec.cls = rv_pkg::CL_BRANCH;
                dec.use_imm = 1'b0;  // Compare against rs2
                dec.imm     = imm_b;
            end
            rv_pkg::OP_LOAD: begin
                if (funct3 == rv_pkg::F3_W) dec.cls = rv_pkg::CL_LOAD;
            end
            rv_pkg::OP_STORE: begin
                if (funct3 == rv_pkg::F3_W) dec.cls = rv_pkg::CL_STORE;
                dec.imm = imm_s;
            end
            rv_pkg::OP_IMM: dec.cls = rv_pkg::CL_ALU;
            rv_pkg::OP_REG: begin
                dec.cls     = rv_pkg::CL_ALU;
                dec.use_imm = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

/* design/rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [rv_pkg::ILEN-1:0] instruction_i,
    input  logic                    redirect_i,
    input  logic [rv_pkg::XLEN-1:0] target_i,
    input  logic                    replay_i,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output logic [rv_pkg::ILEN-1:0] ir_o,
    output logic                    valid_o
);

    logic bubble;  // Flushes the word fetched behind a redirect or replay

    assign valid_o = !bubble;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_o   <= rv_pkg::RAM_BASE;
            ir_o   <= rv_pkg::NOP_INSN;
            bubble <= 1'b0;
        end else begin
            ir_o <= instruction_i;  // Word at pc_o, every cycle
            if (redirect_i) begin
                pc_o   <= target_i;
                bubble <= 1'b1;
            end else if (replay_i) begin
                // Back to the instruction now executing
                pc_o   <= pc_o - rv_pkg::PC_STEP;
                bubble <= 1'b1;
            end else begin
                pc_o   <= pc_o + rv_pkg::PC_STEP;
                bubble <= 1'b0;
            end
        end
    end

endmodule

/* design/rv_decode_if.sv */
`timescale 1ns/1ps

interface rv_decode_if;

    logic                             valid;    // Low in a bubble cycle
    rv_pkg::insn_class_t              cls;
    rv_pkg::alu_op_t                  alu_op;
    logic                             use_imm;  // Operand b is imm instead of rs2
    logic [2:0]                       funct3;
    logic [rv_pkg::REG_ADDR_W-1:0]    rd;
    logic [rv_pkg::REG_ADDR_W-1:0]    rs1;
    logic [rv_pkg::REG_ADDR_W-1:0]    rs2;
    logic [rv_pkg::XLEN-1:0]          imm;

    modport producer (
        output valid, cls, alu_op, use_imm, funct3, rd, rs1, rs2, imm
    );

    modport consumer (
        input  valid, cls, alu_op, use_imm, funct3, rd, rs1, rs2, imm
    );

endinterface

/* design/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RAM_BASE = 64'h0000_0000_8000_0000;
    localparam logic [ILEN-1:0] NOP_INSN = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [XLEN-1:0] PC_STEP  = 64'd4;

    // Major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // Arithmetic funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_W    = 3'b010;  // Word size for LW and SW

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_PASS  // Forwards pc plus immediate, used by AUIPC
    } alu_op_t;

    typedef enum logic [2:0] {
        CL_ALU, CL_BRANCH, CL_JAL, CL_JALR, CL_LOAD, CL_STORE, CL_NONE
    } insn_class_t;

endpackage
